//--- bp_cfg_pkg.sv
package bp_cfg_pkg;

  // Where the single cycle of IF to ID buffering lives
  // SRAM reads combinationally and the IF/ID register holds the result
  // BRAM registers its own lookup and the IF/ID register passes it along
  typedef enum logic {
    MEM_SRAM = 1'b0,
    MEM_BRAM = 1'b1
  } mem_type_e;

  // Address and data width of the core
  localparam int XLEN = 32;

  // Fetch starts here after reset unless the top level overrides it
  localparam logic [XLEN-1:0] RESET_PC_DEFAULT = 32'h0000_1000;

  // Fetch step for uncompressed instructions
  localparam int INSTR_BYTES = 4;

endpackage

//--- bp_types_pkg.sv
package bp_types_pkg;

  // Kind of control transfer recorded in the BTB and seen at resolve
  typedef enum logic [1:0] {
    BR_BRANCH = 2'd0,
    BR_CALL   = 2'd1,
    BR_RET    = 2'd2
  } br_kind_e;

  // BTB answer for one fetch PC
  // All fields are zero on a miss
  typedef struct packed {
    logic                          hit;
    logic                          taken;
    br_kind_e                      kind;
    logic [bp_cfg_pkg::XLEN-1:0]   target;
  } btb_pred_t;

  // Top of the return address stack
  typedef struct packed {
    logic                          valid;
    logic [bp_cfg_pkg::XLEN-1:0]   target;
  } ras_pred_t;

  // Redirect from execute, valid for one cycle
  typedef struct packed {
    logic                          valid;
    logic [bp_cfg_pkg::XLEN-1:0]   target;
  } redirect_t;

  // Training record from the resolve point, valid for one cycle
  typedef struct packed {
    logic                          valid;
    logic [bp_cfg_pkg::XLEN-1:0]   pc;
    logic [bp_cfg_pkg::XLEN-1:0]   target;
    logic                          taken;
    br_kind_e                      kind;
  } resolve_t;

  // Everything the ID stage sees for the instruction it holds
  typedef struct packed {
    logic                          valid;
    logic [bp_cfg_pkg::XLEN-1:0]   pc;
    btb_pred_t                     btb;
    ras_pred_t                     ras;
  } id_bundle_t;

endpackage

//--- bpred_front.f
bp_cfg_pkg.sv
bp_types_pkg.sv
fetch_pc_gen.sv
btb.sv
ras.sv
if_id_pred_reg.sv
bpred_front.sv
tb_clk_gen.sv
tb_bpred_checker.sv
tb_bpred_front.sv

//--- bpred_front.sv
`timescale 1ns/1ns

module bpred_front #(
  parameter bp_cfg_pkg::mem_type_e       MEM_TYPE     = bp_cfg_pkg::MEM_SRAM,
  parameter int                          BTB_IDX_BITS = 4,
  parameter int                          RAS_DEPTH    = 4,
  parameter logic [bp_cfg_pkg::XLEN-1:0] RESET_PC     = bp_cfg_pkg::RESET_PC_DEFAULT
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        stall,
  input  bp_types_pkg::redirect_t     redirect,
  input  bp_types_pkg::resolve_t      resolve,
  output logic [bp_cfg_pkg::XLEN-1:0] fetch_pc,
  output bp_types_pkg::id_bundle_t    id
);

  logic                        flush;
  logic [bp_cfg_pkg::XLEN-1:0] id_pc;
  logic                        id_valid;

  // IF side predictions, before the IF/ID boundary
  bp_types_pkg::btb_pred_t     if_btb;
  bp_types_pkg::ras_pred_t     if_ras;

  // ID side predictions, after the IF/ID boundary
  bp_types_pkg::btb_pred_t     id_btb;
  bp_types_pkg::ras_pred_t     id_ras;

  // PC walk, ID PC/valid and the flush decision
  fetch_pc_gen #(
    .RESET_PC (RESET_PC)
  ) fetch_pc_gen_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (stall),
    .redirect (redirect),
    .id_btb   (id_btb),
    .id_ras   (id_ras),
    .fetch_pc (fetch_pc),
    .id_pc    (id_pc),
    .id_valid (id_valid),
    .flush    (flush)
  );

  btb #(
    .MEM_TYPE     (MEM_TYPE),
    .BTB_IDX_BITS (BTB_IDX_BITS)
  ) btb_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (stall),
    .flush    (flush),
    .fetch_pc (fetch_pc),
    .resolve  (resolve),
    .pred     (if_btb)
  );

  ras #(
    .MEM_TYPE  (MEM_TYPE),
    .RAS_DEPTH (RAS_DEPTH)
  ) ras_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .stall   (stall),
    .flush   (flush),
    .resolve (resolve),
    .pred    (if_ras)
  );

  // One stage register per payload; only one side of each pair buffers
  if_id_pred_reg #(
    .MEM_TYPE  (MEM_TYPE),
    .payload_t (bp_types_pkg::btb_pred_t)
  ) btb_pred_reg_i (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .flush  (flush),
    .din    (if_btb),
    .dout   (id_btb)
  );

  if_id_pred_reg #(
    .MEM_TYPE  (MEM_TYPE),
    .payload_t (bp_types_pkg::ras_pred_t)
  ) ras_pred_reg_i (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .flush  (flush),
    .din    (if_ras),
    .dout   (id_ras)
  );

  // ID bundle out to decode
  assign id.valid = id_valid;
  assign id.pc    = id_pc;
  assign id.btb   = id_btb;
  assign id.ras   = id_ras;

endmodule

//--- btb.sv
`timescale 1ns/1ns

module btb #(
  parameter bp_cfg_pkg::mem_type_e MEM_TYPE     = bp_cfg_pkg::MEM_SRAM,
  parameter int                    BTB_IDX_BITS = 4
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        stall,
  input  logic                        flush,
  input  logic [bp_cfg_pkg::XLEN-1:0] fetch_pc,
  input  bp_types_pkg::resolve_t      resolve,
  output bp_types_pkg::btb_pred_t     pred
);

  localparam int XLEN     = bp_cfg_pkg::XLEN;
  localparam int DEPTH    = 1 << BTB_IDX_BITS;
  // Bits [1:0] are always zero, index sits right above them
  localparam int TAG_BITS = XLEN - BTB_IDX_BITS - 2;

  typedef struct packed {
    logic                   valid;
    logic [TAG_BITS-1:0]    tag;
    logic [XLEN-1:0]        target;
    logic                   taken;
    bp_types_pkg::br_kind_e kind;
  } entry_t;

  entry_t                  entries [DEPTH];
  logic [BTB_IDX_BITS-1:0] rd_idx;
  logic [TAG_BITS-1:0]     rd_tag;
  logic [BTB_IDX_BITS-1:0] wr_idx;
  logic [TAG_BITS-1:0]     wr_tag;
  entry_t                  rd_entry;
  bp_types_pkg::btb_pred_t lookup;

  // Lookup side uses the fetch PC
  assign rd_idx   = fetch_pc[BTB_IDX_BITS+1:2];
  assign rd_tag   = fetch_pc[XLEN-1:BTB_IDX_BITS+2];
  assign rd_entry = entries[rd_idx];

  // Training side uses the resolved branch PC
  assign wr_idx = resolve.pc[BTB_IDX_BITS+1:2];
  assign wr_tag = resolve.pc[XLEN-1:BTB_IDX_BITS+2];

  // Entry table, cleared so a fresh BTB never hits
  // Written at the edge, so the new entry is visible from the next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries[i] <= '0;
      end
    end else if (resolve.valid) begin
      entries[wr_idx] <= '{
        valid:  1'b1,
        tag:    wr_tag,
        target: resolve.target,
        taken:  resolve.taken,
        kind:   resolve.kind
      };
    end
  end

  // Tag compare, miss gives an all-zero prediction
  always_comb begin
    lookup = '0;
    if (rd_entry.valid && (rd_entry.tag == rd_tag)) begin
      lookup.hit    = 1'b1;
      lookup.taken  = rd_entry.taken;
      lookup.kind   = rd_entry.kind;
      lookup.target = rd_entry.target;
    end
  end

  if (MEM_TYPE == bp_cfg_pkg::MEM_BRAM) begin : g_registered
    // BRAM style: output register doubles as the IF/ID stage
    bp_types_pkg::btb_pred_t pred_q;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        pred_q <= '0;
      end else if (flush) begin
        pred_q <= '0;
      end else if (!stall) begin
        pred_q <= lookup;
      end
    end

    assign pred = pred_q;
  end else begin : g_comb
    // SRAM style: IF/ID register downstream does the buffering
    assign pred = lookup;
  end

  // Returns always transfer control, so resolve must never train one as not-taken
  a_ret_is_taken : assert property (
    @(posedge clk) disable iff (!arst_n)
    (resolve.valid && (resolve.kind == bp_types_pkg::BR_RET)) |-> resolve.taken
  );

endmodule

//--- fetch_pc_gen.sv
`timescale 1ns/1ns

module fetch_pc_gen #(
  parameter logic [bp_cfg_pkg::XLEN-1:0] RESET_PC = bp_cfg_pkg::RESET_PC_DEFAULT
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        stall,
  input  bp_types_pkg::redirect_t     redirect,
  input  bp_types_pkg::btb_pred_t     id_btb,
  input  bp_types_pkg::ras_pred_t     id_ras,
  output logic [bp_cfg_pkg::XLEN-1:0] fetch_pc,
  output logic [bp_cfg_pkg::XLEN-1:0] id_pc,
  output logic                        id_valid,
  output logic                        flush
);

  logic                        pred_taken;
  logic                        use_ras;
  logic [bp_cfg_pkg::XLEN-1:0] pred_target;
  logic [bp_cfg_pkg::XLEN-1:0] seq_pc;
  logic [bp_cfg_pkg::XLEN-1:0] next_pc;

  // Prediction only counts for a live instruction in ID
  assign pred_taken = id_valid && id_btb.hit && id_btb.taken;

  // Returns take the stack top when there is one, else the BTB target
  assign use_ras     = (id_btb.kind == bp_types_pkg::BR_RET) && id_ras.valid;
  assign pred_target = use_ras ? id_ras.target : id_btb.target;

  assign seq_pc = fetch_pc + bp_cfg_pkg::XLEN'(bp_cfg_pkg::INSTR_BYTES);

  // Redirect always kills IF/ID
  // A taken prediction kills the fall-through fetch behind it, but not under stall
  assign flush = redirect.valid || (!stall && pred_taken);

  // Next PC in priority order
  always_comb begin
    if (redirect.valid) begin
      next_pc = redirect.target;
    end else if (stall) begin
      next_pc = fetch_pc;
    end else if (pred_taken) begin
      next_pc = pred_target;
    end else begin
      next_pc = seq_pc;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_pc <= RESET_PC;
      id_pc    <= '0;
      id_valid <= 1'b0;
    end else begin
      fetch_pc <= next_pc;
      if (flush) begin
        // ID PC keeps its old value; valid low marks it dead
        id_valid <= 1'b0;
      end else if (!stall) begin
        id_pc    <= fetch_pc;
        id_valid <= 1'b1;
      end
    end
  end

  // Redirect targets and BTB/RAS targets must all keep fetch word aligned
  a_fetch_pc_aligned : assert property (
    @(posedge clk) disable iff (!arst_n)
    fetch_pc[1:0] == 2'b00
  );

endmodule

//--- if_id_pred_reg.sv
`timescale 1ns/1ns

module if_id_pred_reg #(
  parameter bp_cfg_pkg::mem_type_e MEM_TYPE = bp_cfg_pkg::MEM_SRAM,
  parameter type                   payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     stall,
  input  logic     flush,
  input  payload_t din,
  output payload_t dout
);

  if (MEM_TYPE == bp_cfg_pkg::MEM_SRAM) begin : g_buffered
    // Combinational lookup upstream, so the stage register lives here
    payload_t dout_q;

    // Flush wins over stall so a redirect under stall still kills the slot
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        dout_q <= '0;
      end else if (flush) begin
        dout_q <= '0;
      end else if (!stall) begin
        dout_q <= din;
      end
    end

    assign dout = dout_q;
  end else begin : g_passthrough
    // Upstream memory already registered its output
    assign dout = din;
  end

  // For BRAM this holds only because btb and ras clear the same way
  a_flush_clears : assert property (
    @(posedge clk) disable iff (!arst_n)
    flush |=> (dout == '0)
  );

endmodule

//--- ras.sv
`timescale 1ns/1ns

module ras #(
  parameter bp_cfg_pkg::mem_type_e MEM_TYPE  = bp_cfg_pkg::MEM_SRAM,
  parameter int                    RAS_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    stall,
  input  logic                    flush,
  input  bp_types_pkg::resolve_t  resolve,
  output bp_types_pkg::ras_pred_t pred
);

  localparam int XLEN     = bp_cfg_pkg::XLEN;
  localparam int PTR_BITS = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(RAS_DEPTH + 1);

  logic [XLEN-1:0]         stack [RAS_DEPTH];
  logic [PTR_BITS-1:0]     top_ptr;
  logic [PTR_BITS-1:0]     push_ptr;
  logic [PTR_BITS-1:0]     pop_ptr;
  logic [CNT_BITS-1:0]     count;
  logic                    push;
  logic                    pop;
  bp_types_pkg::ras_pred_t lookup;

  // Calls push their return address, returns pop
  assign push = resolve.valid && (resolve.kind == bp_types_pkg::BR_CALL);
  // Pop on an empty stack is dropped
  assign pop  = resolve.valid && (resolve.kind == bp_types_pkg::BR_RET) && (count != '0);

  // Pointer wraps explicitly so depths that are not a power of two still work
  assign push_ptr = (top_ptr == PTR_BITS'(RAS_DEPTH - 1)) ? '0 : top_ptr + 1'b1;
  assign pop_ptr  = (top_ptr == '0) ? PTR_BITS'(RAS_DEPTH - 1) : top_ptr - 1'b1;

  // Storage, written on push only
  // When full the push lands on the oldest slot, which is what we want
  always_ff @(posedge clk) begin
    if (push) begin
      stack[push_ptr] <= resolve.pc + XLEN'(bp_cfg_pkg::INSTR_BYTES);
    end
  end

  // Top pointer and saturating occupancy count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      top_ptr <= '0;
      count   <= '0;
    end else if (push) begin
      top_ptr <= push_ptr;
      if (count != CNT_BITS'(RAS_DEPTH)) begin
        count <= count + 1'b1;
      end
    end else if (pop) begin
      top_ptr <= pop_ptr;
      count   <= count - 1'b1;
    end
  end

  // Empty stack shows a zero target rather than stale storage
  assign lookup.valid  = (count != '0);
  assign lookup.target = lookup.valid ? stack[top_ptr] : '0;

  if (MEM_TYPE == bp_cfg_pkg::MEM_BRAM) begin : g_registered
    bp_types_pkg::ras_pred_t pred_q;

    // Same hold and clear rules as the IF/ID register it replaces
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        pred_q <= '0;
      end else if (flush) begin
        pred_q <= '0;
      end else if (!stall) begin
        pred_q <= lookup;
      end
    end

    assign pred = pred_q;
  end else begin : g_comb
    assign pred = lookup;
  end

  a_count_bounded : assert property (
    @(posedge clk) disable iff (!arst_n)
    count <= CNT_BITS'(RAS_DEPTH)
  );

endmodule

//--- tb_bpred_checker.sv
`timescale 1ns/1ns

module tb_bpred_checker #(
  parameter int                          BTB_IDX_BITS = 4,
  parameter int                          RAS_DEPTH    = 4,
  parameter logic [bp_cfg_pkg::XLEN-1:0] RESET_PC     = bp_cfg_pkg::RESET_PC_DEFAULT
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        stall,
  input  bp_types_pkg::redirect_t     redirect,
  input  bp_types_pkg::resolve_t      resolve,
  input  logic [bp_cfg_pkg::XLEN-1:0] fetch_pc,
  input  bp_types_pkg::id_bundle_t    id,
  output int                          check_count,
  output int                          error_count
);

  localparam int BTB_DEPTH = 1 << BTB_IDX_BITS;

  // Model fetch and ID state
  logic [31:0]             m_fetch_pc;
  logic [31:0]             m_id_pc;
  logic                    m_id_valid;
  bp_types_pkg::btb_pred_t m_id_btb;
  bp_types_pkg::ras_pred_t m_id_ras;

  // Model BTB keeps the whole branch PC instead of a tag
  logic                    m_btb_valid  [BTB_DEPTH];
  logic [31:0]             m_btb_pc     [BTB_DEPTH];
  logic [31:0]             m_btb_target [BTB_DEPTH];
  logic                    m_btb_taken  [BTB_DEPTH];
  bp_types_pkg::br_kind_e  m_btb_kind   [BTB_DEPTH];

  // Model RAS as a queue, newest entry at the back
  logic [31:0]             m_ras [$];

  function automatic bp_types_pkg::btb_pred_t ref_btb_lookup(input logic [31:0] pc);
    int                      idx;
    bp_types_pkg::btb_pred_t p;
    idx = (pc >> 2) % BTB_DEPTH;
    p   = '0;
    // Same slot only counts when the upper PC bits agree
    if (m_btb_valid[idx] &&
        ((m_btb_pc[idx] >> (BTB_IDX_BITS + 2)) == (pc >> (BTB_IDX_BITS + 2)))) begin
      p.hit    = 1'b1;
      p.taken  = m_btb_taken[idx];
      p.kind   = m_btb_kind[idx];
      p.target = m_btb_target[idx];
    end
    return p;
  endfunction

  function automatic bp_types_pkg::ras_pred_t ref_ras_top();
    bp_types_pkg::ras_pred_t p;
    p = '0;
    if (m_ras.size() > 0) begin
      p.valid  = 1'b1;
      p.target = m_ras[$];
    end
    return p;
  endfunction

  // Next fetch PC from the priority list
  function automatic logic [31:0] ref_next_pc(input logic stl, input logic taken);
    if (redirect.valid) begin
      return redirect.target;
    end else if (stl) begin
      return m_fetch_pc;
    end else if (taken) begin
      if (m_id_btb.kind == bp_types_pkg::BR_RET && m_id_ras.valid) begin
        return m_id_ras.target;
      end
      return m_id_btb.target;
    end
    return m_fetch_pc + 32'd4;
  endfunction

  // Model steps on the same edge as the DUT, inputs are stable there
  always @(posedge clk or negedge arst_n) begin : model_step
    logic                    taken;
    logic                    flush;
    logic [31:0]             next_pc;
    bp_types_pkg::btb_pred_t look_btb;
    bp_types_pkg::ras_pred_t look_ras;
    int                      idx;
    if (!arst_n) begin
      m_fetch_pc = RESET_PC;
      m_id_pc    = '0;
      m_id_valid = 1'b0;
      m_id_btb   = '0;
      m_id_ras   = '0;
      for (int i = 0; i < BTB_DEPTH; i++) begin
        m_btb_valid[i] = 1'b0;
      end
      m_ras.delete();
    end else begin
      taken    = m_id_valid && m_id_btb.hit && m_id_btb.taken;
      flush    = redirect.valid || (!stall && taken);
      next_pc  = ref_next_pc(stall, taken);
      // Lookups see the tables before this edge's training
      look_btb = ref_btb_lookup(m_fetch_pc);
      look_ras = ref_ras_top();
      if (flush) begin
        m_id_valid = 1'b0;
        m_id_btb   = '0;
        m_id_ras   = '0;
      end else if (!stall) begin
        m_id_pc    = m_fetch_pc;
        m_id_valid = 1'b1;
        m_id_btb   = look_btb;
        m_id_ras   = look_ras;
      end
      if (resolve.valid) begin
        idx                = (resolve.pc >> 2) % BTB_DEPTH;
        m_btb_valid[idx]   = 1'b1;
        m_btb_pc[idx]      = resolve.pc;
        m_btb_target[idx]  = resolve.target;
        m_btb_taken[idx]   = resolve.taken;
        m_btb_kind[idx]    = resolve.kind;
        if (resolve.kind == bp_types_pkg::BR_CALL) begin
          // Full stack drops its oldest address
          if (m_ras.size() == RAS_DEPTH) begin
            void'(m_ras.pop_front());
          end
          m_ras.push_back(resolve.pc + 32'd4);
        end else if (resolve.kind == bp_types_pkg::BR_RET && m_ras.size() > 0) begin
          void'(m_ras.pop_back());
        end
      end
      m_fetch_pc = next_pc;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
  end

  // Compare mid-cycle, away from the edge
  always @(negedge clk) begin
    if (arst_n === 1'b1) begin
      check_value("fetch_pc", fetch_pc, m_fetch_pc);
      check_value("id.valid", id.valid, m_id_valid);
      check_value("id.pc", id.pc, m_id_pc);
      check_value("id.btb.hit", id.btb.hit, m_id_btb.hit);
      check_value("id.btb.taken", id.btb.taken, m_id_btb.taken);
      check_value("id.btb.kind", 32'(id.btb.kind), 32'(m_id_btb.kind));
      check_value("id.btb.target", id.btb.target, m_id_btb.target);
      check_value("id.ras.valid", id.ras.valid, m_id_ras.valid);
      check_value("id.ras.target", id.ras.target, m_id_ras.target);
    end
  end

endmodule

//--- tb_bpred_front.sv
`timescale 1ns/1ns

module tb_bpred_front #(
  parameter bp_cfg_pkg::mem_type_e MEM_TYPE = bp_cfg_pkg::MEM_SRAM
);

  localparam int          BTB_IDX_BITS = 4;
  localparam int          RAS_DEPTH    = 4;
  localparam logic [31:0] RESET_PC     = bp_cfg_pkg::RESET_PC_DEFAULT;
  localparam int          STALL_CYCLES = 40;
  localparam int          MIX_CYCLES   = 300;
  // Rough cycle budget of all tests, directed ones included
  localparam int          TEST_CYCLES  = 150 + STALL_CYCLES + MIX_CYCLES + 4 * RAS_DEPTH;
  localparam int          WATCHDOG_NS  = TEST_CYCLES * 10 + 1000;

  logic                     clk;
  logic                     arst_n;
  logic                     stall;
  bp_types_pkg::redirect_t  redirect;
  bp_types_pkg::resolve_t   resolve;
  logic [31:0]              fetch_pc;
  bp_types_pkg::id_bundle_t id;
  int                       check_count;
  int                       error_count;
  int                       tb_checks;
  int                       tb_errors;
  int                       test_num;
  int                       errors_before;
  logic [31:0]              rng_state;

  tb_clk_gen #(
    .PERIOD_NS    (10),
    .RESET_CYCLES (4)
  ) clk_gen_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  bpred_front #(
    .MEM_TYPE     (MEM_TYPE),
    .BTB_IDX_BITS (BTB_IDX_BITS),
    .RAS_DEPTH    (RAS_DEPTH),
    .RESET_PC     (RESET_PC)
  ) bpred_front_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (stall),
    .redirect (redirect),
    .resolve  (resolve),
    .fetch_pc (fetch_pc),
    .id       (id)
  );

  tb_bpred_checker #(
    .BTB_IDX_BITS (BTB_IDX_BITS),
    .RAS_DEPTH    (RAS_DEPTH),
    .RESET_PC     (RESET_PC)
  ) checker_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .redirect    (redirect),
    .resolve     (resolve),
    .fetch_pc    (fetch_pc),
    .id          (id),
    .check_count (check_count),
    .error_count (error_count)
  );

  // LCG, constants from Numerical Recipes
  function automatic logic [31:0] rand_word();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // One clock, then drop the one-cycle strobes
  task automatic tick();
    @(posedge clk);
    #1;
    redirect = '0;
    resolve  = '0;
  endtask

  task automatic train(input logic [31:0] pc, input logic [31:0] target,
                       input logic taken, input bp_types_pkg::br_kind_e kind);
    resolve.valid  = 1'b1;
    resolve.pc     = pc;
    resolve.target = target;
    resolve.taken  = taken;
    resolve.kind   = kind;
    tick();
  endtask

  task automatic redirect_to(input logic [31:0] target);
    redirect.valid  = 1'b1;
    redirect.target = target;
    tick();
  endtask

  task automatic check_port(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    tb_checks++;
    if (got !== exp) begin
      tb_errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Follow fetch until it lands on the expected PC, bounded
  task automatic wait_fetch(input logic [31:0] exp, input string what);
    int n;
    n = 0;
    while (fetch_pc !== exp && n < 8) begin
      tick();
      n++;
    end
    tb_checks++;
    if (fetch_pc !== exp) begin
      tb_errors++;
      $display("%s: fetch never reached %h within 8 cycles", what, exp);
    end
  endtask

  task automatic end_test(input string name);
    int total;
    total = error_count + tb_errors;
    test_num++;
    $display("Test %0d %s finished with %0d errors", test_num, name, total - errors_before);
    errors_before = total;
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    logic [31:0]            r;
    logic [31:0]            s;
    bp_types_pkg::br_kind_e kind;
    rng_state     = 32'h059c_e20b;
    stall         = 1'b0;
    redirect      = '0;
    resolve       = '0;
    tb_checks     = 0;
    tb_errors     = 0;
    test_num      = 0;
    errors_before = 0;
    wait (arst_n === 1'b1);

    // Reset state and the plain sequential walk
    check_port("fetch_pc", fetch_pc, RESET_PC);
    check_port("id.valid", id.valid, 1'b0);
    repeat (12) tick();
    check_port("fetch_pc", fetch_pc, RESET_PC + 32'd48);
    end_test("reset and sequential fetch");

    repeat (STALL_CYCLES) begin
      r     = rand_word();
      stall = (r[31:30] == 2'b00);
      tick();
    end
    stall = 1'b0;
    tick();
    end_test("random stall");

    redirect_to(32'h0000_2000);
    check_port("fetch_pc", fetch_pc, 32'h0000_2000);
    check_port("id.valid", id.valid, 1'b0);
    repeat (3) tick();
    end_test("redirect");

    // Taken branch, then a PC at the same index with another tag
    train(32'h0000_3010, 32'h0000_3400, 1'b1, bp_types_pkg::BR_BRANCH);
    redirect_to(32'h0000_3008);
    wait_fetch(32'h0000_3400, "taken branch");
    redirect_to(32'h0000_3010 + (32'd1 << (BTB_IDX_BITS + 2)));
    repeat (2) tick();
    check_port("fetch_pc", fetch_pc, 32'h0000_3010 + (32'd1 << (BTB_IDX_BITS + 2)) + 32'd8);
    end_test("BTB hit and alias miss");

    // Return trained first, its pop hits an empty stack
    train(32'h0000_5020, 32'h0000_9990, 1'b1, bp_types_pkg::BR_RET);
    train(32'h0000_4000, 32'h0000_5000, 1'b1, bp_types_pkg::BR_CALL);
    redirect_to(32'h0000_5020);
    wait_fetch(32'h0000_4004, "return via RAS");
    // Overflow by more than the depth, the oldest ones go
    for (int i = 1; i <= RAS_DEPTH + 1; i++) begin
      train(32'h0000_4000 + 32'h100 * i, 32'h0000_5000, 1'b1, bp_types_pkg::BR_CALL);
    end
    redirect_to(32'h0000_5020);
    wait_fetch(32'h0000_4004 + 32'h100 * (RAS_DEPTH + 1), "return after overflow");
    repeat (RAS_DEPTH - 1) begin
      train(32'h0000_5020, 32'h0000_9990, 1'b1, bp_types_pkg::BR_RET);
    end
    redirect_to(32'h0000_5020);
    wait_fetch(32'h0000_4204, "oldest surviving return");
    train(32'h0000_5020, 32'h0000_9990, 1'b1, bp_types_pkg::BR_RET);
    redirect_to(32'h0000_5020);
    wait_fetch(32'h0000_9990, "empty RAS fallback");
    end_test("calls and returns");

    // Mixed traffic around the reset PC so entries get reused
    repeat (MIX_CYCLES) begin
      r     = rand_word();
      s     = rand_word();
      stall = (r[31:30] == 2'b00);
      if (r[29:26] == 4'd0) begin
        redirect.valid  = 1'b1;
        redirect.target = RESET_PC + {22'd0, s[31:24], 2'b00};
      end
      if (r[25:24] == 2'd1) begin
        kind = (r[23:22] == 2'd3) ? bp_types_pkg::BR_BRANCH : bp_types_pkg::br_kind_e'(r[23:22]);
        resolve.valid  = 1'b1;
        resolve.pc     = r[20] ? fetch_pc : RESET_PC + {22'd0, s[23:16], 2'b00};
        resolve.target = RESET_PC + {22'd0, s[15:8], 2'b00};
        resolve.kind   = kind;
        resolve.taken  = (kind == bp_types_pkg::BR_RET) || r[21];
      end
      tick();
    end
    stall = 1'b0;
    repeat (2) tick();
    end_test("mixed random traffic");

    $display("Checks %0d, errors %0d", check_count + tb_checks, error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lines up with the stimulus offset after the edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

endmodule
